// File: common/xadc_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths, limits and word layouts for the ADC readout
////////////////////////////////////////////////////////////////////////////

package xadc_pkg;

    // ADC result width
    localparam int unsigned sample_w = 12;

    // Samples packed into one FIFO word
    localparam int unsigned slots_per_word = 5;

    // Forced frame end after this many words
    localparam int unsigned max_words = 150;

    // PDO channels, one per VMM
    localparam int unsigned vmm_count = 8;

    typedef logic [sample_w-1:0] sample_t;   // One conversion result

    typedef logic [2:0] vmm_sel_t;           // VMM / channel index

    typedef logic [8:0] word_cnt_t;          // Words in the current frame

    ////////////////////////////////////////////////////////////////////////
    // FIFO word
    //   [63]    always zero
    //   [62:60] VMM index
    //   [59:0]  slot 4 .. slot 0, slot 0 in the low bits
    ////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic                               hdr_zero;
        vmm_sel_t                           vmm;
        sample_t [slots_per_word-1:0]       slot;
    } pdo_word_t;

    ////////////////////////////////////////////////////////////////////////
    // Run request settings
    ////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [3:0]     vmm_id;         // 0..7 one VMM, 8..15 all VMMs
        logic [10:0]    sample_size;    // Conversions per VMM
        logic [17:0]    delay_in;       // Idle cycles between conversions
    } run_cfg_t;

endpackage

// File: rtl/xadc_sequencer.sv
`timescale 1ns/1ns

module xadc_sequencer (
    input  logic                clk125,
    input  logic                rst,
    input  logic                run_req,
    input  xadc_pkg::run_cfg_t  cfg,
    input  logic                udp_done,
    input  logic                read_done,
    input  logic                frame_end,
    output logic                busy,
    output logic                read_req,
    output xadc_pkg::vmm_sel_t  vmm_sel,
    output logic                flush
);
    import xadc_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ,
        S_WAIT,
        S_DELAY,
        S_FLUSH,
        S_DONE
    } seq_state_t;

    seq_state_t     st;
    run_cfg_t       cfg_r;
    logic           all_vmm;
    logic [10:0]    sample_cnt;     // Reads issued for the current VMM
    logic [17:0]    delay_cnt;

    assign all_vmm = cfg_r.vmm_id[3];   // Ids 8..15 sweep every VMM

    // Settings held for the whole run
    always_ff @(posedge clk125)
    begin
        if (st == S_IDLE && run_req)
            cfg_r <= cfg;
    end

    ////////////////////////////////////////////////////////////////////////
    // Run control
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            st         <= S_IDLE;
            busy       <= 1'b0;
            read_req   <= 1'b0;
            flush      <= 1'b0;
            vmm_sel    <= '0;
            sample_cnt <= '0;
            delay_cnt  <= '0;
        end
        else
        begin
            read_req <= 1'b0;
            case (st)
                S_IDLE:
                begin
                    if (run_req)
                    begin
                        busy       <= 1'b1;
                        vmm_sel    <= cfg.vmm_id[3] ? vmm_sel_t'(0) : cfg.vmm_id[2:0];
                        sample_cnt <= '0;
                        st         <= S_READ;
                    end
                end

                S_READ:     // First read of the run
                begin
                    read_req   <= 1'b1;
                    sample_cnt <= sample_cnt + 11'd1;
                    st         <= S_WAIT;
                end

                S_WAIT:
                begin
                    if (read_done)
                    begin
                        if (sample_cnt >= cfg_r.sample_size)
                        begin
                            flush <= 1'b1;  // Close the frame
                            st    <= S_FLUSH;
                        end
                        else if (cfg_r.delay_in == '0)
                        begin
                            read_req   <= 1'b1; // Back to back
                            sample_cnt <= sample_cnt + 11'd1;
                        end
                        else
                        begin
                            delay_cnt <= 18'd1;
                            st        <= S_DELAY;
                        end
                    end
                end

                S_DELAY:
                begin
                    if (delay_cnt == cfg_r.delay_in)
                    begin
                        read_req   <= 1'b1;
                        sample_cnt <= sample_cnt + 11'd1;
                        st         <= S_WAIT;
                    end
                    else
                        delay_cnt <= delay_cnt + 18'd1;
                end

                S_FLUSH:
                begin
                    if (frame_end)
                    begin
                        flush <= 1'b0;
                        // Next VMM starts straight away in sweep mode
                        if (all_vmm && vmm_sel < vmm_sel_t'(vmm_count - 1))
                        begin
                            vmm_sel    <= vmm_sel + 3'd1;
                            read_req   <= 1'b1;
                            sample_cnt <= 11'd1;
                            st         <= S_WAIT;
                        end
                        else
                            st <= S_DONE;
                    end
                end

                S_DONE:     // Old request gone and UDP send finished
                begin
                    if (!run_req && udp_done)
                    begin
                        busy <= 1'b0;
                        st   <= S_IDLE;
                    end
                end

                default: st <= S_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/adc_channel_reader.sv
`timescale 1ns/1ns

module adc_channel_reader (
    input  logic                clk125,
    input  logic                rst,
    input  logic                read_req,
    input  xadc_pkg::vmm_sel_t  vmm_sel,
    input  logic                conv_done,
    input  xadc_pkg::sample_t   conv_result,
    output logic                conv_start,
    output xadc_pkg::vmm_sel_t  conv_channel,
    output logic                sample_valid,
    output xadc_pkg::sample_t   sample,
    output logic                read_done
);

    typedef enum logic [1:0] {
        R_IDLE,
        R_CONV,
        R_DONE
    } rd_state_t;

    rd_state_t st;

    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            st           <= R_IDLE;
            conv_start   <= 1'b0;
            sample_valid <= 1'b0;
            read_done    <= 1'b0;
        end
        else
        begin
            case (st)
                R_IDLE:
                begin
                    read_done <= 1'b0;
                    if (read_req)
                    begin
                        conv_channel <= vmm_sel;    // PDO of the selected VMM
                        conv_start   <= 1'b1;
                        st           <= R_CONV;
                    end
                end

                R_CONV:     // Conversion in flight
                begin
                    conv_start <= 1'b0;
                    if (conv_done)
                    begin
                        sample       <= conv_result;
                        sample_valid <= 1'b1;
                        st           <= R_DONE;
                    end
                end

                R_DONE:
                begin
                    sample_valid <= 1'b0;
                    read_done    <= 1'b1;   // Packer already has the sample
                    st           <= R_IDLE;
                end

                default: st <= R_IDLE;
            endcase
        end
    end

endmodule

// File: packet/pdo_packer.sv
`timescale 1ns/1ns

module pdo_packer (
    input  logic                    clk125,
    input  logic                    rst,
    input  logic                    sample_valid,
    input  xadc_pkg::sample_t       sample,
    input  xadc_pkg::vmm_sel_t      vmm_sel,
    input  logic                    word_clear,
    input  logic                    frame_clear,
    output xadc_pkg::pdo_word_t     word,
    output logic                    word_full,
    output logic                    word_pending,
    output xadc_pkg::word_cnt_t     word_count
);
    import xadc_pkg::*;

    logic [2:0] fill;       // Slots written in the open word
    logic       slot_wr;

    // Extra samples on a full word are dropped until the writer clears it
    assign slot_wr      = sample_valid && (fill < 3'(slots_per_word));
    assign word_pending = (fill != 3'd0);

    ////////////////////////////////////////////////////////////////////////
    // Slot filling
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            fill      <= '0;
            word_full <= 1'b0;
            word      <= '0;
        end
        else
        begin
            word_full <= 1'b0;
            if (word_clear)
            begin
                fill <= '0;
                word <= '0;     // Unused slots read back as zero
            end
            else if (slot_wr)
            begin
                word.hdr_zero   <= 1'b0;
                word.vmm        <= vmm_sel;
                word.slot[fill] <= sample;
                fill            <= fill + 3'd1;
                if (fill == 3'(slots_per_word - 1))
                    word_full <= 1'b1;  // Same edge as the last slot
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Words started in this frame
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk125)
    begin
        if (rst || frame_clear)
            word_count <= '0;
        else if (slot_wr && !word_clear && fill == 3'd0)
            word_count <= word_count + 9'd1;    // Count on the first slot
    end

endmodule

// File: packet/frame_writer.sv
`timescale 1ns/1ns

module frame_writer (
    input  logic                    clk125,
    input  logic                    rst,
    input  logic                    word_full,
    input  logic                    word_pending,
    input  logic                    flush,
    input  xadc_pkg::pdo_word_t     word,
    input  xadc_pkg::word_cnt_t     word_count,
    output logic                    fifo_wr,
    output xadc_pkg::pdo_word_t     fifo_data,
    output xadc_pkg::word_cnt_t     packet_len,
    output logic                    end_of_data,
    output logic                    frame_end,
    output logic                    word_clear,
    output logic                    frame_clear
);
    import xadc_pkg::*;

    typedef enum logic [1:0] {
        W_IDLE,
        W_WRITE,
        W_CLEAR,
        W_GAP
    } wr_state_t;

    wr_state_t  st;
    logic       accept;
    logic       close_frame;

    assign accept      = (st == W_IDLE) && (word_full || flush);
    assign close_frame = flush || (word_count == word_cnt_t'(max_words));

    // Word and length held for the FIFO
    always_ff @(posedge clk125)
    begin
        if (accept)
        begin
            fifo_data  <= word;
            packet_len <= word_count;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // FIFO write sequence
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            st          <= W_IDLE;
            fifo_wr     <= 1'b0;
            end_of_data <= 1'b0;
            frame_end   <= 1'b0;
            word_clear  <= 1'b0;
            frame_clear <= 1'b0;
        end
        else
        begin
            case (st)
                W_IDLE:
                begin
                    if (accept)
                    begin
                        fifo_wr     <= word_pending;    // Empty flush skips the write
                        end_of_data <= close_frame;
                        frame_end   <= close_frame;
                        frame_clear <= close_frame;
                        st          <= W_WRITE;
                    end
                end

                W_WRITE:
                begin
                    fifo_wr     <= 1'b0;
                    frame_end   <= 1'b0;
                    frame_clear <= 1'b0;
                    word_clear  <= 1'b1;
                    st          <= W_CLEAR;
                end

                W_CLEAR:    // end_of_data spans two cycles
                begin
                    word_clear  <= 1'b0;
                    end_of_data <= 1'b0;
                    st          <= W_GAP;
                end

                W_GAP: st <= W_IDLE;

                default: st <= W_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/xadc_readout.sv
`timescale 1ns/1ns

module xadc_readout (
    input  logic                    clk125,
    input  logic                    rst,
    input  logic                    run_req,
    input  xadc_pkg::run_cfg_t      cfg,
    input  logic                    udp_done,
    input  logic                    conv_done,
    input  xadc_pkg::sample_t       conv_result,
    output logic                    busy,
    output logic                    conv_start,
    output xadc_pkg::vmm_sel_t      conv_channel,
    output logic                    fifo_wr,
    output xadc_pkg::pdo_word_t     fifo_data,
    output xadc_pkg::word_cnt_t     packet_len,
    output logic                    end_of_data
);
    import xadc_pkg::*;

    ////////////////////////////////////////////////////////////////////////
    // Internal links
    ////////////////////////////////////////////////////////////////////////
    logic       read_req;
    logic       read_done;
    vmm_sel_t   vmm_sel;
    logic       flush;
    logic       frame_end;
    logic       sample_valid;
    sample_t    sample;
    logic       word_full;
    logic       word_pending;
    pdo_word_t  word;
    word_cnt_t  word_count;
    logic       word_clear;
    logic       frame_clear;

    xadc_sequencer u_sequencer (
        .clk125     (clk125),
        .rst        (rst),
        .run_req    (run_req),
        .cfg        (cfg),
        .udp_done   (udp_done),
        .read_done  (read_done),
        .frame_end  (frame_end),
        .busy       (busy),
        .read_req   (read_req),
        .vmm_sel    (vmm_sel),
        .flush      (flush)
    );

    adc_channel_reader u_reader (
        .clk125         (clk125),
        .rst            (rst),
        .read_req       (read_req),
        .vmm_sel        (vmm_sel),
        .conv_done      (conv_done),
        .conv_result    (conv_result),
        .conv_start     (conv_start),
        .conv_channel   (conv_channel),
        .sample_valid   (sample_valid),
        .sample         (sample),
        .read_done      (read_done)
    );

    pdo_packer u_packer (
        .clk125         (clk125),
        .rst            (rst),
        .sample_valid   (sample_valid),
        .sample         (sample),
        .vmm_sel        (vmm_sel),
        .word_clear     (word_clear),
        .frame_clear    (frame_clear),
        .word           (word),
        .word_full      (word_full),
        .word_pending   (word_pending),
        .word_count     (word_count)
    );

    frame_writer u_writer (
        .clk125         (clk125),
        .rst            (rst),
        .word_full      (word_full),
        .word_pending   (word_pending),
        .flush          (flush),
        .word           (word),
        .word_count     (word_count),
        .fifo_wr        (fifo_wr),
        .fifo_data      (fifo_data),
        .packet_len     (packet_len),
        .end_of_data    (end_of_data),
        .frame_end      (frame_end),
        .word_clear     (word_clear),
        .frame_clear    (frame_clear)
    );

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk125,
    output logic rst
);

    // 20 ns period
    initial
    begin
        clk125 = 1'b0;
        forever #10 clk125 = ~clk125;
    end

    initial
    begin
        rst <= 1'b1;
        repeat (10) @(posedge clk125);  // Ten cycles in reset
        rst <= 1'b0;
    end

endmodule

// File: testbench/tb_xadc_readout.sv
`timescale 1ns/1ns

module tb_xadc_readout;
    import xadc_pkg::*;

    logic           clk125;
    logic           rst;
    logic           run_req;
    run_cfg_t       cfg;
    logic           udp_done;
    logic           conv_done;
    sample_t        conv_result;
    logic           busy;
    logic           conv_start;
    vmm_sel_t       conv_channel;
    logic           fifo_wr;
    pdo_word_t      fifo_data;
    word_cnt_t      packet_len;
    logic           end_of_data;

    pdo_word_t      wr_data[$];     // Captured FIFO writes
    word_cnt_t      wr_len[$];
    logic           wr_eod[$];
    logic           wr_eod2[$];     // end_of_data one cycle after each write
    int             cs_cycle[$];    // conv_start times and channels
    vmm_sel_t       cs_chan[$];
    logic           eod_follow = 1'b0;
    int             cycle = 0;

    int             conv_count = 0; // ADC model state
    int             adc_wait = 0;
    vmm_sel_t       adc_chan;
    logic           start_seen;

    int             err_count = 0;
    int             check_count = 0;
    int             tests_run = 0;
    int             tests_failed = 0;
    int             sample_base;

    tb_clock_gen clock_gen (.clk125(clk125), .rst(rst));

    xadc_readout UUT (
        .clk125         (clk125),
        .rst            (rst),
        .run_req        (run_req),
        .cfg            (cfg),
        .udp_done       (udp_done),
        .conv_done      (conv_done),
        .conv_result    (conv_result),
        .busy           (busy),
        .conv_start     (conv_start),
        .conv_channel   (conv_channel),
        .fifo_wr        (fifo_wr),
        .fifo_data      (fifo_data),
        .packet_len     (packet_len),
        .end_of_data    (end_of_data)
    );

    ////////////////////////////////////////////////////////////////////////
    // ADC model and monitors
    ////////////////////////////////////////////////////////////////////////
    function automatic sample_t adc_value(input vmm_sel_t ch, input int k);
        return sample_t'((int'(ch) * 256 + k) & 32'hfff);
    endfunction

    function automatic pdo_word_t expect_word(input vmm_sel_t ch, input int first,
                                              input int count);
        pdo_word_t w;
        w     = '0;
        w.vmm = ch;
        for (int i = 0; i < count; i++)
            w.slot[3'(i)] = adc_value(ch, first + i);   // Higher slots stay zero
        return w;
    endfunction

    // Six cycles from conv_start to conv_done
    initial
    begin
        conv_done   <= 1'b0;
        conv_result <= '0;
        forever
        begin
            @(negedge clk125);
            start_seen = (conv_start === 1'b1);
            if (start_seen)
                adc_chan = conv_channel;
            @(posedge clk125);
            conv_done <= 1'b0;
            if (start_seen)
                adc_wait = 6;
            else if (adc_wait > 0)
            begin
                adc_wait = adc_wait - 1;
                if (adc_wait == 0)
                begin
                    conv_result <= adc_value(adc_chan, conv_count);
                    conv_done   <= 1'b1;
                    conv_count  = conv_count + 1;
                end
            end
        end
    end

    always @(posedge clk125)
        cycle = cycle + 1;

    always @(negedge clk125)
    begin
        if (eod_follow)
            wr_eod2.push_back(end_of_data);
        eod_follow = (fifo_wr === 1'b1);
        if (fifo_wr === 1'b1)
        begin
            wr_data.push_back(fifo_data);
            wr_len.push_back(packet_len);
            wr_eod.push_back(end_of_data);
        end
        if (conv_start === 1'b1)
        begin
            cs_cycle.push_back(cycle);
            cs_chan.push_back(conv_channel);
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Compares and reporting
    ////////////////////////////////////////////////////////////////////////
    task automatic check_word(input string name, input pdo_word_t got, input pdo_word_t exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("ERROR %s: expected 0x%h, got 0x%h", name, exp, got);
        end
    endtask

    task automatic check_len(input string name, input word_cnt_t got, input word_cnt_t exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("ERROR %s: expected 0x%h, got 0x%h", name, exp, got);
        end
    endtask

    task automatic check_chan(input string name, input vmm_sel_t got, input vmm_sel_t exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("ERROR %s: expected 0x%h, got 0x%h", name, exp, got);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("ERROR %s: expected 0x%h, got 0x%h", name, exp, got);
        end
    endtask

    task automatic note_failure(input string msg);
        err_count++;
        $display("%s", msg);
    endtask

    task automatic report_test(input string name, input int errs_before);
        int errs;
        errs = err_count - errs_before;
        tests_run++;
        if (errs != 0)
            tests_failed++;
        $display("Test %s: %s (%0d errors)", name, errs == 0 ? "ok" : "failed", errs);
    endtask

    task automatic check_write(input int idx, input pdo_word_t exp_word,
                               input word_cnt_t exp_len, input logic exp_eod);
        if (idx >= wr_data.size())
            note_failure($sformatf("FIFO write %0d never happened", idx));
        else
        begin
            check_word($sformatf("fifo_data[%0d]", idx), wr_data[idx], exp_word);
            check_len($sformatf("packet_len[%0d]", idx), wr_len[idx], exp_len);
            check_level($sformatf("end_of_data[%0d]", idx), wr_eod[idx], exp_eod);
            if (idx < wr_eod2.size())
                check_level($sformatf("end_of_data[%0d] +1", idx), wr_eod2[idx], exp_eod);
        end
    endtask

    task automatic check_write_count(input int n);
        if (wr_data.size() != n)
            note_failure($sformatf("Expected %0d FIFO writes, saw %0d", n, wr_data.size()));
    endtask

    task automatic check_conv_channels(input int n, input vmm_sel_t ch);
        if (cs_chan.size() != n)
            note_failure($sformatf("Expected %0d conversions, saw %0d", n, cs_chan.size()));
        foreach (cs_chan[i])
            check_chan($sformatf("conv_channel[%0d]", i), cs_chan[i], ch);
    endtask

    task automatic check_idle_outputs;
        check_level("busy", busy, 1'b0);
        check_level("conv_start", conv_start, 1'b0);
        check_level("fifo_wr", fifo_wr, 1'b0);
        check_level("end_of_data", end_of_data, 1'b0);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Run control
    ////////////////////////////////////////////////////////////////////////
    task automatic start_run(input logic [3:0] vmm_id, input int size, input int delay);
        run_cfg_t c;
        c.vmm_id      = vmm_id;
        c.sample_size = 11'(size);
        c.delay_in    = 18'(delay);
        @(negedge clk125);
        sample_base = conv_count;
        @(posedge clk125);
        wr_data.delete();
        wr_len.delete();
        wr_eod.delete();
        wr_eod2.delete();
        cs_cycle.delete();
        cs_chan.delete();
        cfg     <= c;
        run_req <= 1'b1;
        repeat (2) @(negedge clk125);
        check_level("busy", busy, 1'b1);    // One cycle after run_req
    endtask

    task automatic wait_writes(input int n);
        while (wr_data.size() < n)
            @(posedge clk125);
    endtask

    // busy needs both the request gone and the UDP send done
    task automatic finish_run;
        @(posedge clk125);
        udp_done <= 1'b1;
        repeat (4) @(negedge clk125);
        check_level("busy", busy, 1'b1);
        @(posedge clk125);
        udp_done <= 1'b0;
        run_req  <= 1'b0;
        repeat (4) @(negedge clk125);
        check_level("busy", busy, 1'b1);
        @(posedge clk125);
        udp_done <= 1'b1;
        repeat (2) @(negedge clk125);
        check_level("busy", busy, 1'b0);
        @(posedge clk125);
        udp_done <= 1'b0;
        repeat (2) @(posedge clk125);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////
    task automatic reset_values;
        int errs_before;
        errs_before = err_count;
        @(posedge clk125);  // First reset edge
        do
        begin
            @(negedge clk125);
            check_idle_outputs();
        end
        while (rst);
        repeat (5)
        begin
            @(negedge clk125);
            check_idle_outputs();
        end
        report_test("reset", errs_before);
    endtask

    task automatic single_vmm_frame;
        int errs_before;
        errs_before = err_count;
        start_run(4'd5, 3, 4);
        wait_writes(1);
        finish_run();
        check_conv_channels(3, 3'd5);
        check_write(0, expect_word(3'd5, sample_base, 3), 9'd1, 1'b1);
        check_write_count(1);
        report_test("single_vmm", errs_before);
    endtask

    task automatic two_word_frame;
        int errs_before;
        errs_before = err_count;
        start_run(4'd2, 7, 3);
        wait_writes(2);
        finish_run();
        check_conv_channels(7, 3'd2);
        check_write(0, expect_word(3'd2, sample_base, 5), 9'd1, 1'b0);
        check_write(1, expect_word(3'd2, sample_base + 5, 2), 9'd2, 1'b1);
        check_write_count(2);
        report_test("two_words", errs_before);
    endtask

    task automatic all_vmm_sweep;
        int errs_before;
        errs_before = err_count;
        start_run(4'd9, 2, 1);
        wait_writes(8);
        finish_run();
        if (cs_chan.size() != 16)
            note_failure($sformatf("Expected 16 conversions, saw %0d", cs_chan.size()));
        foreach (cs_chan[i])
            check_chan($sformatf("conv_channel[%0d]", i), cs_chan[i], vmm_sel_t'(i / 2));
        for (int v = 0; v < 8; v++)     // One frame per VMM
            check_write(v, expect_word(vmm_sel_t'(v), sample_base + 2 * v, 2), 9'd1, 1'b1);
        check_write_count(8);
        report_test("all_vmm", errs_before);
    endtask

    task automatic conversion_delay;
        int errs_before;
        int gap;
        errs_before = err_count;
        start_run(4'd6, 4, 40);
        wait_writes(1);
        finish_run();
        check_conv_channels(4, 3'd6);
        for (int i = 1; i < cs_cycle.size(); i++)
        begin
            gap = cs_cycle[i] - cs_cycle[i-1];
            if (gap < 41)
                note_failure($sformatf("conv_start %0d came only %0d cycles after the last",
                                       i, gap));
        end
        check_write(0, expect_word(3'd6, sample_base, 4), 9'd1, 1'b1);
        check_write_count(1);
        report_test("delay", errs_before);
    endtask

    task automatic frame_limit;
        int errs_before;
        errs_before = err_count;
        start_run(4'd3, 752, 0);
        wait_writes(151);
        finish_run();
        check_conv_channels(752, 3'd3);
        for (int w = 0; w < 150; w++)
            check_write(w, expect_word(3'd3, sample_base + 5 * w, 5),
                        word_cnt_t'(w + 1), w == 149);
        check_write(150, expect_word(3'd3, sample_base + 750, 2), 9'd1, 1'b1);
        check_write_count(151);
        report_test("frame_limit", errs_before);
    endtask

    // Samples times (delay_in + 20) over all runs, plus margin
    initial
    begin
        int limit;
        limit = 3 * (4 + 20) + 7 * (3 + 20) + 16 * (1 + 20) + 4 * (40 + 20)
              + 752 * (0 + 20) + 2000;
        repeat (limit) @(posedge clk125);
        $display("Timeout: tests still running after %0d cycles", limit);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial
    begin
        run_req  <= 1'b0;
        udp_done <= 1'b0;
        cfg      <= '0;
        reset_values();
        single_vmm_frame();
        two_word_frame();
        all_vmm_sweep();
        conversion_delay();
        frame_limit();
        $display("Tests: %0d run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, err_count);
        if (err_count == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: xadc_readout.f
common/xadc_pkg.sv
rtl/xadc_sequencer.sv
rtl/adc_channel_reader.sv
packet/pdo_packer.sv
packet/frame_writer.sv
rtl/xadc_readout.sv
testbench/tb_clock_gen.sv
testbench/tb_xadc_readout.sv

// File: Makefile
SIM      := verilator
TOP      := tb_xadc_readout
FILELIST := xadc_readout.f
FLAGS    := --binary --timing --timescale 1ns/1ns -j 0
OBJ_DIR  := obj_dir
PASS_MSG := SIMULATION PASSED

BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
